//--- execStage.f
logic/isaPkg.sv
logic/execPkg.sv
logic/cla16.sv
logic/alu.sv
logic/branchUnit.sv
logic/execute.sv
logic/executeStage.sv
test/executeStageTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= execStage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard logic/*.sv test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test verdict
run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- test/executeStageTb.sv
// needs a simulator with timing support; expected values are hand-computed for 16-bit data and stop at the first mismatch
`timescale 1ns/100ps

module executeStageTb;

   import isaPkg::*;
   import execPkg::*;

   // cycles that any single handshake wait may take
   localparam int waitLimit = 64;

   logic        clk;
   logic        reset;
   execItem_t   item;
   logic        inValid;
   logic        inReady;
   execResult_t result;
   logic        outValid;
   logic        outReady;

   integer      seed;
   // stimulus and expected result share an index
   execItem_t   stimItem[$];
   execResult_t expResult[$];
   // control bundle and incremented pc for the next rows
   execCtl_t    ctl;
   logic [15:0] casePc;

   executeStage executeStage_i (
      .clk      (clk),
      .reset    (reset),
      .item     (item),
      .inValid  (inValid),
      .inReady  (inReady),
      .result   (result),
      .outValid (outValid),
      .outReady (outReady)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   // one table row, instr carries only the major opcode and func
   task automatic addCase(
      input majorOp_t    major,
      input logic [1:0]  func,
      input logic [15:0] rs,
      input logic [15:0] rt,
      input logic [15:0] imm,
      input logic [15:0] expOut,
      input logic [15:0] expPc,
      input logic        expZero,
      input logic        expOfl
   );
      execItem_t   stim;
      execResult_t exp;
      stim                     = '0;
      stim.ctl                 = ctl;
      stim.instr.regForm.major = major;
      stim.instr.regForm.func  = func;
      stim.regData1            = rs;
      stim.regData2            = rt;
      stim.immVal              = imm;
      stim.incPc               = casePc;
      exp.out                  = expOut;
      exp.newPc                = expPc;
      exp.zero                 = expZero;
      exp.ofl                  = expOfl;
      stimItem.push_back(stim);
      expResult.push_back(exp);
   endtask

   task automatic buildTable;
      // register form, func picks add or xor andn
      ctl    = '0;
      casePc = 16'h0100;
      addCase(opArith, 2'b00, 16'h1234, 16'h0101, 16'h0000, 16'h1335, 16'h0100, 0, 0);
      addCase(opArith, 2'b01, 16'h00f0, 16'h0f00, 16'h0000, 16'h0ff0, 16'h0100, 0, 0);
      addCase(opArith, 2'b10, 16'hff00, 16'h0ff0, 16'h0000, 16'hf0f0, 16'h0100, 0, 0);
      addCase(opArith, 2'b11, 16'hf0f0, 16'hff00, 16'h0000, 16'h00f0, 16'h0100, 0, 0);
      // subtract as ~rs + rt + 1
      ctl.invA = 1'b1;
      addCase(opArith, 2'b00, 16'h0005, 16'h000c, 16'h0000, 16'h0007, 16'h0100, 0, 0);
      addCase(opArith, 2'b00, 16'h4321, 16'h4321, 16'h0000, 16'h0000, 16'h0100, 1, 0);
      // immediate form
      ctl         = '0;
      ctl.immPres = 1'b1;
      ctl.aluSrc  = 1'b1;
      addCase(opAddi, 2'b00, 16'h7fff, 16'h0000, 16'h0001, 16'h8000, 16'h0100, 0, 1);
      addCase(opXori, 2'b00, 16'h1234, 16'h0000, 16'hffff, 16'hedcb, 16'h0100, 0, 0);
      addCase(opAndni, 2'b00, 16'h1234, 16'h0000, 16'h000f, 16'h1230, 16'h0100, 0, 0);
      addCase(opSrli, 2'b00, 16'h8421, 16'h0000, 16'h0001, 16'h4210, 16'h0100, 0, 0);
      addCase(opSlli, 2'b00, 16'h8421, 16'h0000, 16'h0000, 16'h8421, 16'h0100, 0, 0);
      // load address is always an add
      ctl.memAccess = 1'b1;
      addCase(opLd, 2'b00, 16'h1000, 16'h0000, 16'hfffe, 16'h0ffe, 16'h0100, 0, 0);
      // high byte from rs, low byte from the immediate
      ctl.memAccess = 1'b0;
      ctl.slbi      = 1'b1;
      addCase(opSlbi, 2'b00, 16'hab12, 16'h0000, 16'h0034, 16'h1234, 16'h0100, 0, 0);
      // register rotates and shifts, amount in rt
      ctl = '0;
      addCase(opShift, 2'b00, 16'h8421, 16'h0000, 16'h0000, 16'h8421, 16'h0100, 0, 0);
      addCase(opShift, 2'b00, 16'h8421, 16'h0001, 16'h0000, 16'h0843, 16'h0100, 0, 0);
      addCase(opShift, 2'b00, 16'h8421, 16'h000f, 16'h0000, 16'hc210, 16'h0100, 0, 0);
      addCase(opShift, 2'b01, 16'h8421, 16'h0000, 16'h0000, 16'h8421, 16'h0100, 0, 0);
      addCase(opShift, 2'b01, 16'h8421, 16'h0001, 16'h0000, 16'h0842, 16'h0100, 0, 0);
      addCase(opShift, 2'b01, 16'h8421, 16'h000f, 16'h0000, 16'h8000, 16'h0100, 0, 0);
      addCase(opShift, 2'b10, 16'h8421, 16'h0000, 16'h0000, 16'h8421, 16'h0100, 0, 0);
      addCase(opShift, 2'b10, 16'h8421, 16'h0001, 16'h0000, 16'hc210, 16'h0100, 0, 0);
      addCase(opShift, 2'b10, 16'h8421, 16'h000f, 16'h0000, 16'h0843, 16'h0100, 0, 0);
      addCase(opShift, 2'b11, 16'h8421, 16'h0000, 16'h0000, 16'h8421, 16'h0100, 0, 0);
      addCase(opShift, 2'b11, 16'h8421, 16'h0001, 16'h0000, 16'h4210, 16'h0100, 0, 0);
      addCase(opShift, 2'b11, 16'h8421, 16'h000f, 16'h0000, 16'h0001, 16'h0100, 0, 0);
      // seq and sle leave a rotate on the alu, so zero and ofl follow it
      ctl.setKind = setSeq;
      addCase(opSeq, 2'b00, 16'h8005, 16'h8005, 16'h0000, 16'h0001, 16'h0100, 0, 1);
      addCase(opSeq, 2'b00, 16'h0003, 16'h0002, 16'h0000, 16'h0000, 16'h0100, 0, 0);
      ctl.setKind = setSlt;
      addCase(opSlt, 2'b00, 16'hfffe, 16'h0003, 16'h0000, 16'h0001, 16'h0100, 0, 0);
      addCase(opSlt, 2'b00, 16'h0003, 16'hfffe, 16'h0000, 16'h0000, 16'h0100, 0, 0);
      ctl.setKind = setSle;
      addCase(opSle, 2'b00, 16'hfffb, 16'hfffb, 16'h0000, 16'h0001, 16'h0100, 0, 0);
      addCase(opSle, 2'b00, 16'h0004, 16'hfff0, 16'h0000, 16'h0000, 16'h0100, 0, 0);
      addCase(opSle, 2'b00, 16'h8000, 16'h0001, 16'h0000, 16'h0001, 16'h0100, 0, 0);
      // carry out, the alu sum itself is zero in the first row
      ctl.setKind = setSco;
      addCase(opSco, 2'b00, 16'hffff, 16'h0001, 16'h0000, 16'h0001, 16'h0100, 1, 0);
      addCase(opSco, 2'b00, 16'h0001, 16'h0002, 16'h0000, 16'h0000, 16'h0100, 0, 0);
      ctl     = '0;
      ctl.btr = 1'b1;
      addCase(opBtr, 2'b00, 16'h1234, 16'h0000, 16'h0000, 16'h2c48, 16'h0100, 0, 0);
      // jal returns incPc and jumps pc-relative
      ctl         = '0;
      ctl.immPres = 1'b1;
      ctl.aluSrc  = 1'b1;
      ctl.jump    = 1'b1;
      ctl.link    = 1'b1;
      casePc      = 16'h0200;
      addCase(opJal, 2'b00, 16'h0000, 16'h0000, 16'h0010, 16'h0200, 16'h0210, 1, 0);
      ctl.link = 1'b0;
      addCase(opJ, 2'b00, 16'h0003, 16'h0000, 16'h0040, 16'h0003, 16'h0240, 0, 0);
      ctl.jumpReg = 1'b1;
      addCase(opJr, 2'b00, 16'h0300, 16'h0000, 16'h0008, 16'h0308, 16'h0308, 0, 0);
      // branches test rs plus zero
      ctl         = '0;
      ctl.immPres = 1'b1;
      ctl.aluSrc  = 1'b1;
      ctl.branch  = 1'b1;
      casePc      = 16'h0100;
      addCase(opBeqz, 2'b00, 16'h0000, 16'h0000, 16'h0020, 16'h0000, 16'h0120, 1, 0);
      addCase(opBeqz, 2'b00, 16'h0005, 16'h0000, 16'h0020, 16'h0005, 16'h0100, 0, 0);
      addCase(opBnez, 2'b00, 16'h0005, 16'h0000, 16'hfff0, 16'h0005, 16'h00f0, 0, 0);
      addCase(opBnez, 2'b00, 16'h0000, 16'h0000, 16'hfff0, 16'h0000, 16'h0100, 1, 0);
      addCase(opBltz, 2'b00, 16'h8000, 16'h0000, 16'h0020, 16'h8000, 16'h0120, 0, 0);
      addCase(opBltz, 2'b00, 16'h0001, 16'h0000, 16'h0020, 16'h0001, 16'h0100, 0, 0);
      addCase(opBgez, 2'b00, 16'h0007, 16'h0000, 16'hfff0, 16'h0007, 16'h00f0, 0, 0);
      addCase(opBgez, 2'b00, 16'hffff, 16'h0000, 16'hfff0, 16'hffff, 16'h0100, 0, 0);
   endtask

   task automatic checkResult(input execResult_t expected);
      if (result.out !== expected.out) begin
         failRun($sformatf("ERROR result.out expected %h actual %h",
                           expected.out, result.out));
      end
      if (result.zero !== expected.zero) begin
         failRun($sformatf("ERROR result.zero expected %h actual %h",
                           expected.zero, result.zero));
      end
      if (result.ofl !== expected.ofl) begin
         failRun($sformatf("ERROR result.ofl expected %h actual %h",
                           expected.ofl, result.ofl));
      end
   endtask

   task automatic checkPc(input logic [15:0] expected);
      if (result.newPc !== expected) begin
         failRun($sformatf("ERROR result.newPc expected %h actual %h",
                           expected, result.newPc));
      end
   endtask

   // returns on the edge that takes the item
   task automatic waitAccept(input bit streaming);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!inReady) begin
         if (streaming) begin
            failRun("inReady went low while outReady was held high");
         end
         cycles++;
         if (cycles > waitLimit) begin
            failRun("timeout: inReady stayed low, the input handshake stalled");
         end
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic driveItems(input bit streaming);
      @(posedge clk);
      foreach (stimItem[i]) begin
         item    <= stimItem[i];
         inValid <= 1'b1;
         waitAccept(streaming);
      end
      inValid <= 1'b0;
   endtask

   // new outReady on the rising edge, look at the handshake mid-cycle
   task automatic stepReady(input bit streaming);
      @(posedge clk);
      outReady <= streaming ? 1'b1 : (($random(seed) & 3) != 0);
      @(negedge clk);
   endtask

   task automatic waitResult(input bit streaming);
      int cycles;
      cycles = 0;
      stepReady(streaming);
      while (!(outValid && outReady)) begin
         cycles++;
         if (cycles > waitLimit) begin
            failRun("timeout: no result transfer, the output handshake stalled");
         end
         stepReady(streaming);
      end
   endtask

   task automatic collectResults(input bit streaming);
      foreach (expResult[i]) begin
         waitResult(streaming);
         checkResult(expResult[i]);
         checkPc(expResult[i].newPc);
      end
   endtask

   initial begin
      seed     = 32'h21c4245a;
      reset    = 1'b1;
      item     = '0;
      inValid  = 1'b0;
      outReady = 1'b0;
      buildTable();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (outValid) begin
         failRun("outValid was high right after reset");
      end
      // random back-pressure
      fork
         driveItems(1'b0);
         collectResults(1'b0);
      join
      // back to back, outReady held high
      fork
         driveItems(1'b1);
         collectResults(1'b1);
      join
      @(posedge clk);
      @(negedge clk);
      if (outValid) begin
         failRun("a result came out after the last table entry");
      end
      $display("Test OK");
      $finish;
   end

endmodule

//--- logic/executeStage.sv
// single-entry execute stage; upstream must hold item steady while inValid is high and inReady low
`timescale 1ns/100ps

module executeStage (
   input  logic                 clk,
   input  logic                 reset,
   input  execPkg::execItem_t   item,
   input  logic                 inValid,
   output logic                 inReady,
   output execPkg::execResult_t result,
   output logic                 outValid,
   input  logic                 outReady
);

   import execPkg::*;

   // combinational result of the item on the input
   execResult_t stageResult;
   logic        accept;

   execute execute_i (
      .item   (item),
      .result (stageResult)
   );

   // free when empty or draining this cycle
   assign inReady = !outValid || outReady;
   assign accept  = inValid && inReady;

   // valid flag
   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else if (inReady) begin
         // refill or go empty
         outValid <= inValid;
      end
   end

   // result register, loaded only on a transfer
   always_ff @(posedge clk) begin
      if (accept) begin
         result <= stageResult;
      end
   end

   // a stalled output holds its data and its valid
   assert property (@(posedge clk) disable iff (reset)
      (outValid && !outReady) |=> (outValid && $stable(result)))
      else $error("result changed under back-pressure");

   // upstream holds a waiting item until it is taken
   assert property (@(posedge clk) disable iff (reset)
      (inValid && !inReady) |=> (inValid && $stable(item)))
      else $error("item changed before it was accepted");

endmodule

//--- logic/execute.sv
// combinational execute datapath; at most one of btr, slbi and a set kind may be active per item
`timescale 1ns/100ps

module execute (
   input  execPkg::execItem_t   item,
   output execPkg::execResult_t result
);

   import isaPkg::*;
   import execPkg::*;

   execCtl_t             ctl;
   instrWord_t           instr;
   // alu operands
   logic [wordWidth-1:0] inA;
   logic [wordWidth-1:0] inB;
   aluOp_t               op;
   logic                 carryIn;
   logic [wordWidth-1:0] aluOut;
   logic                 aluZero;
   logic                 aluOfl;
   logic                 carryOut;
   // set-on-compare bit
   logic                 setBit;
   logic [wordWidth-1:0] reversed;

   assign ctl   = item.ctl;
   assign instr = item.instr;

   // slbi puts rs in the high byte, the immediate is or-ed in by the alu
   assign inA = ctl.slbi ? (item.regData1 << 8) : item.regData1;

   // branches test rs plus zero
   assign inB = ctl.branch ? '0 : (ctl.aluSrc ? item.immVal : item.regData2);

   always_comb begin
      if (ctl.memAccess || ctl.jumpReg) begin
         // address and register-jump target are adds
         op = aluAdd;
      end else if (ctl.immPres) begin
         // immediate group, opcode bit 13 picks shift or arithmetic
         op = aluOp_t'({~instr.immForm.major[2], instr.immForm.major[1:0]});
      end else begin
         // register group, opcode bit 11 picks shift or arithmetic
         op = aluOp_t'({instr.regForm.major[0], instr.regForm.func});
      end
   end

   // any inversion needs the +1 for two's complement
   assign carryIn = ctl.invA | ctl.invB;

   alu alu_i (
      .inA      (inA),
      .inB      (inB),
      .op       (op),
      .invA     (ctl.invA),
      .invB     (ctl.invB),
      .carryIn  (carryIn),
      .result   (aluOut),
      .zero     (aluZero),
      .ofl      (aluOfl),
      .carryOut (carryOut)
   );

   branchUnit branchUnit_i (
      .instr   (instr),
      .ctl     (ctl),
      .incPc   (item.incPc),
      .immVal  (item.immVal),
      .aluOut  (aluOut),
      .aluZero (aluZero),
      .newPc   (result.newPc)
   );

   always_comb begin
      case (ctl.setKind)
         setSeq:  setBit = (inA == inB);
         setSlt:  setBit = ($signed(inA) < $signed(inB));
         setSle:  setBit = ($signed(inA) <= $signed(inB));
         setSco:  setBit = carryOut;
         default: setBit = 1'b0;
      endcase
   end

   always_comb begin
      for (int i = 0; i < wordWidth; i++) begin
         reversed[i] = inA[wordWidth-1-i];
      end
   end

   // link wins, then set, then reverse
   always_comb begin
      if (ctl.link) begin
         result.out = item.incPc;
      end else if (ctl.setKind != setNone) begin
         result.out = {{(wordWidth-1){1'b0}}, setBit};
      end else if (ctl.btr) begin
         result.out = reversed;
      end else begin
         result.out = aluOut;
      end
   end

   assign result.zero = aluZero;
   assign result.ofl  = aluOfl;

   // decode must never mix the special result kinds
   always_comb begin
      assert final ($onehot0({ctl.btr, ctl.slbi, ctl.setKind != setNone}))
         else $error("btr, slbi and set kind active together");
   end

endmodule

//--- logic/branchUnit.sv
// next-PC resolution; branch conditions expect aluOut to be rs plus zero, immVal already sign-extended
`timescale 1ns/100ps

module branchUnit (
   input  isaPkg::instrWord_t instr,
   input  execPkg::execCtl_t  ctl,
   input  logic [15:0]        incPc,
   input  logic [15:0]        immVal,
   input  logic [15:0]        aluOut,
   input  logic               aluZero,
   output logic [15:0]        newPc
);

   import isaPkg::*;

   majorOp_t             major;
   // pc-relative target
   logic [wordWidth-1:0] target;
   logic                 isBeqz;
   logic                 isBnez;
   logic                 isBltz;
   logic                 isBgez;
   logic                 taken;

   // the major field sits in the same place in both views
   assign major = instr.immForm.major;

   // own adder so the target does not wait on the alu
   cla16 targetAdder_i (
      .a        (incPc),
      .b        (immVal),
      .carryIn  (1'b0),
      .sum      (target),
      .carryOut ()
   );

   assign isBeqz = (major == opBeqz);
   assign isBnez = (major == opBnez);
   assign isBltz = (major == opBltz);
   assign isBgez = (major == opBgez);

   // zero test uses the alu flag
   // sign test uses bit 15 of rs plus 0
   assign taken = ctl.branch & ((isBeqz & aluZero)
                              | (isBnez & ~aluZero)
                              | (isBltz & aluOut[wordWidth-1])
                              | (isBgez & ~aluOut[wordWidth-1]));

   always_comb begin
      if (ctl.jumpReg) begin
         // jr and jalr, rs plus immediate from the alu
         newPc = aluOut;
      end else if (ctl.jump) begin
         newPc = target;
      end else if (taken) begin
         newPc = target;
      end else begin
         // fall through
         newPc = incPc;
      end
   end

endmodule

//--- logic/alu.sv
// combinational ALU; shifts use only inB[3:0], and ofl is meaningful for the add op alone
`timescale 1ns/100ps

module alu (
   input  logic [15:0]    inA,
   input  logic [15:0]    inB,
   input  isaPkg::aluOp_t op,
   input  logic           invA,
   input  logic           invB,
   input  logic           carryIn,
   output logic [15:0]    result,
   output logic           zero,
   output logic           ofl,
   output logic           carryOut
);

   import isaPkg::*;

   // operands after optional inversion
   logic [wordWidth-1:0]     opA;
   logic [wordWidth-1:0]     opB;
   logic [wordWidth-1:0]     addSum;
   logic [shiftAmtWidth-1:0] shiftAmt;
   // doubled operand so a rotate is a plain shift
   logic [2*wordWidth-1:0]   rotLeft;
   logic [2*wordWidth-1:0]   rotRight;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // subtract is ~A + B + 1, carry-in comes from execute
   cla16 adder_i (
      .a        (opA),
      .b        (opB),
      .carryIn  (carryIn),
      .sum      (addSum),
      .carryOut (carryOut)
   );

   assign shiftAmt = opB[shiftAmtWidth-1:0];
   assign rotLeft  = {opA, opA} << shiftAmt;
   assign rotRight = {opA, opA} >> shiftAmt;

   always_comb begin
      case (op)
         aluRol: result = rotLeft[2*wordWidth-1:wordWidth];
         aluSll: result = opA << shiftAmt;
         aluRor: result = rotRight[wordWidth-1:0];
         aluSrl: result = opA >> shiftAmt;
         aluAdd: result = addSum;
         aluOr:  result = opA | opB;
         aluXor: result = opA ^ opB;
         // andn, A and not B
         default: result = opA & ~opB;
      endcase
   end

   assign zero = (result == '0);

   // same-sign operands giving a sum of the other sign
   assign ofl = (opA[wordWidth-1] == opB[wordWidth-1])
              & (addSum[wordWidth-1] != opA[wordWidth-1]);

   // op is derived in execute from the instruction word
   // an unknown op with live operands means decode handed over garbage
   always_comb begin
      if (!$isunknown(inA) || !$isunknown(inB)) begin
         assert final (!$isunknown(op))
            else $error("alu op unknown while operands are driven");
      end
   end

endmodule

//--- logic/cla16.sv
// unsigned 16-bit add with two lookahead levels; carryOut is the true carry of a + b + carryIn
`timescale 1ns/100ps

module cla16 (
   input  logic [15:0] a,
   input  logic [15:0] b,
   input  logic        carryIn,
   output logic [15:0] sum,
   output logic        carryOut
);

   // per-bit generate and propagate
   logic [15:0] gen;
   logic [15:0] prop;
   // per-group terms
   logic [3:0]  groupGen;
   logic [3:0]  groupProp;
   // carry into each group, index 4 is the carry out
   logic [4:0]  groupCarry;
   // carry into each bit
   logic [15:0] bitCarry;

   assign gen  = a & b;
   assign prop = a ^ b;

   // first level inside each 4-bit group
   for (genvar g = 0; g < 4; g++) begin : groupLevel
      logic [3:0] gg;
      logic [3:0] pp;
      logic       cin;
      assign gg  = gen[4*g +: 4];
      assign pp  = prop[4*g +: 4];
      assign cin = groupCarry[g];
      assign groupGen[g]  = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                          | (pp[3] & pp[2] & pp[1] & gg[0]);
      assign groupProp[g] = &pp;
      assign bitCarry[4*g]   = cin;
      assign bitCarry[4*g+1] = gg[0] | (pp[0] & cin);
      assign bitCarry[4*g+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cin);
      assign bitCarry[4*g+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                             | (pp[2] & pp[1] & pp[0] & cin);
   end

   // second level across the groups
   assign groupCarry[0] = carryIn;
   assign groupCarry[1] = groupGen[0] | (groupProp[0] & carryIn);
   assign groupCarry[2] = groupGen[1] | (groupProp[1] & groupGen[0])
                        | (&groupProp[1:0] & carryIn);
   assign groupCarry[3] = groupGen[2] | (groupProp[2] & groupGen[1])
                        | (&groupProp[2:1] & groupGen[0]) | (&groupProp[2:0] & carryIn);
   assign groupCarry[4] = groupGen[3] | (groupProp[3] & groupGen[2])
                        | (&groupProp[3:2] & groupGen[1]) | (&groupProp[3:1] & groupGen[0])
                        | (&groupProp & carryIn);

   assign sum      = prop ^ bitCarry;
   assign carryOut = groupCarry[4];

endmodule

//--- logic/execPkg.sv
// execute stage bundles; decode is trusted to give a consistent ctl, and immVal arrives already sign-extended
package execPkg;

   // set-on-compare kind
   // slt and sle compare signed, sco returns the adder carry-out
   typedef enum logic [2:0] {
      setNone = 3'd0,
      setSeq  = 3'd1,
      setSlt  = 3'd2,
      setSle  = 3'd3,
      setSco  = 3'd4
   } setKind_t;

   // control bundle from decode
   typedef struct packed {
      // immediate view of the instruction picks the alu op
      logic     immPres;
      // operand B is the immediate
      logic     aluSrc;
      // operand A is rs shifted left by 8
      logic     slbi;
      // result is operand A bit-reversed
      logic     btr;
      logic     invA;
      logic     invB;
      setKind_t setKind;
      logic     jump;
      // jump target comes from the alu
      logic     jumpReg;
      // result is the incremented pc
      logic     link;
      logic     branch;
      // load or store forces an address add
      logic     memAccess;
   } execCtl_t;

   // one item handed over by decode
   typedef struct packed {
      execCtl_t                         ctl;
      isaPkg::instrWord_t               instr;
      logic [isaPkg::wordWidth-1:0]     regData1;
      logic [isaPkg::wordWidth-1:0]     regData2;
      logic [isaPkg::wordWidth-1:0]     immVal;
      logic [isaPkg::wordWidth-1:0]     incPc;
   } execItem_t;

   // what the stage returns
   typedef struct packed {
      logic [isaPkg::wordWidth-1:0] out;
      logic [isaPkg::wordWidth-1:0] newPc;
      // alu result all zeros
      logic                         zero;
      // signed overflow of the add
      logic                         ofl;
   } execResult_t;

endpackage

//--- logic/isaPkg.sv
// ISA view of the 16-bit load/store machine; the ALU code order is fixed by the op derivation in execute
package isaPkg;

   // machine word width
   localparam int wordWidth = 16;
   // rotate and shift amounts use the low bits of operand B
   localparam int shiftAmtWidth = 4;

   // alu operation codes
   // the low half is rotate and shift, the high half is arithmetic and logic
   typedef enum logic [2:0] {
      aluRol  = 3'b000,
      aluSll  = 3'b001,
      aluRor  = 3'b010,
      aluSrl  = 3'b011,
      aluAdd  = 3'b100,
      aluOr   = 3'b101,
      aluXor  = 3'b110,
      aluAndn = 3'b111
   } aluOp_t;

   // major opcode in instr[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opBtr   = 5'b11001,
      opShift = 5'b11010,
      opArith = 5'b11011,
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } majorOp_t;

   // immediate form
   typedef struct packed {
      majorOp_t   major;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } immForm_t;

   // register form, func selects within the major group
   typedef struct packed {
      majorOp_t   major;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } regForm_t;

   // one instruction word, read either way
   typedef union packed {
      immForm_t immForm;
      regForm_t regForm;
   } instrWord_t;

endpackage
